//--- hw/car_mover.sv
// ==========================================================
// Car column registers, all cars shift right on each update
// A car leaving the last column reenters at column zero
// ==========================================================
`timescale 1ns/1ps

module car_mover
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        update,
    output game_geometry_pkg::coord_x_t car_x [game_geometry_pkg::N_CARS]
);

    import game_geometry_pkg::*;

    // Advanced column per car
    coord_x_t next_x [N_CARS];

    always_comb
    begin
        for (int i = 0; i < N_CARS; i++)
        begin
            // Wrap at the right edge
            if (car_x[i] == MAX_X)
                next_x[i] = 8'd0;
            else
                next_x[i] = car_x[i] + 8'd1;
        end
    end

    // Lanes are fixed rows, only the columns move
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Cars spread evenly across the road
            for (int i = 0; i < N_CARS; i++)
                car_x[i] <= coord_x_t'(i * CAR_SPACING);
        end
        else if (update)
        begin
            for (int i = 0; i < N_CARS; i++)
                car_x[i] <= next_x[i];
        end
    end

endmodule

//--- hw/game_control.sv
// ==========================================================
// Game control FSM, waits for start then paces the updates
// Drives the divider enable and the mover update strobe
// ==========================================================
`timescale 1ns/1ps

module game_control
(
    input  logic clock,
    input  logic rst_n,
    input  logic start_game,
    input  logic tick,
    output logic running,
    output logic update
);

    import game_timing_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // Next state logic
    always_comb
    begin
        next_state = state;
        case (state)
            // Idle until the player presses start
            S_WAIT:
            begin
                if (start_game)
                    next_state = S_WAIT_FOR_TICK;
            end
            S_WAIT_FOR_TICK:
            begin
                if (tick)
                    next_state = S_UPDATE;
            end
            // Single update cycle, then back to waiting
            S_UPDATE:
            begin
                next_state = S_WAIT_FOR_TICK;
            end
            default:
            begin
                next_state = S_WAIT;
            end
        endcase
    end

    // State register
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            state <= S_WAIT;
        else
            state <= next_state;
    end

    // Once started the game never leaves the running states
    assign running = (state != S_WAIT);
    assign update  = (state == S_UPDATE);

endmodule

//--- hw/game_geometry_pkg.sv
// ==========================================================
// Grid size, zone limits and start positions of the game
// Imported by the movers and used for port types of the core
// ==========================================================
package game_geometry_pkg;

    // One column of the 160 wide grid
    typedef logic [7:0] coord_x_t;

    // One row of the 120 high grid
    typedef logic [6:0] coord_y_t;

    // Grid edges
    localparam coord_x_t MAX_X = 8'd159;
    localparam coord_y_t MAX_Y = 7'd119;

    // Road zone on top, safe zone right below it
    localparam coord_y_t WAR_Y_MAX = 7'd99;
    localparam coord_y_t SAFE_Y_MIN = WAR_Y_MAX + 7'd1;

    // Player starts in the middle of the safe zone
    localparam coord_x_t PLAYER_START_X = 8'd80;
    localparam coord_y_t PLAYER_START_Y = SAFE_Y_MIN + 7'd10;

    // Car group layout
    localparam int N_CARS = 4;
    // Start column step, car i at i * CAR_SPACING
    localparam int CAR_SPACING = 40;

endpackage

//--- hw/game_timing_pkg.sv
// ==========================================================
// Game tick rate and control state encoding
// Shared by the control FSM and the tick divider
// ==========================================================
package game_timing_pkg;

    // Clock cycles per game tick, raise for real hardware
    localparam int TICK_PERIOD = 8;

    // Divider count, holds 0 to TICK_PERIOD - 1
    typedef logic [3:0] tick_count_t;

    // Value where the divider wraps
    localparam tick_count_t TICK_LAST = tick_count_t'(TICK_PERIOD - 1);

    // Control FSM states
    typedef enum logic [1:0] {
        S_WAIT          = 2'd0,
        S_WAIT_FOR_TICK = 2'd1,
        S_UPDATE        = 2'd2
    } ctrl_state_t;

endpackage

//--- hw/player_mover.sv
// ==========================================================
// Player position registers and one step per game update
// Buttons are active low, priority up, down, left, right
// ==========================================================
`timescale 1ns/1ps

module player_mover
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        update,
    input  logic                        up,
    input  logic                        down,
    input  logic                        left,
    input  logic                        right,
    output game_geometry_pkg::coord_x_t player_x,
    output game_geometry_pkg::coord_y_t player_y
);

    import game_geometry_pkg::*;

    coord_x_t next_x;
    coord_y_t next_y;

    // Step selection
    always_comb
    begin
        next_x = player_x;
        next_y = player_y;
        // Only the top pressed button counts, even when it is blocked
        if (!up)
        begin
            if (player_y != 7'd0)
                next_y = player_y - 7'd1;
        end
        else if (!down)
        begin
            if (player_y != MAX_Y)
                next_y = player_y + 7'd1;
        end
        else if (!left)
        begin
            if (player_x != 8'd0)
                next_x = player_x - 8'd1;
        end
        else if (!right)
        begin
            if (player_x != MAX_X)
                next_x = player_x + 8'd1;
        end
    end

    // Position registers, load only in the update cycle
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            player_x <= PLAYER_START_X;
            player_y <= PLAYER_START_Y;
        end
        else if (update)
        begin
            player_x <= next_x;
            player_y <= next_y;
        end
    end

endmodule

//--- hw/road_crosser_core.sv
// ==========================================================
// Movement core of the road crossing game
// Connects control FSM, tick divider, player and car movers
// ==========================================================
`timescale 1ns/1ps

module road_crosser_core
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        start_game,
    input  logic                        up,
    input  logic                        down,
    input  logic                        left,
    input  logic                        right,
    output game_geometry_pkg::coord_x_t player_x,
    output game_geometry_pkg::coord_y_t player_y,
    output game_geometry_pkg::coord_x_t car_x [game_geometry_pkg::N_CARS],
    output logic                        frame_update
);

    // Game is past the start screen
    logic running;
    // Divider pulse, one per tick period
    logic tick;
    // Position load strobe for both movers
    logic update;

    game_control u_control
    (
        .clock      (clock),
        .rst_n      (rst_n),
        .start_game (start_game),
        .tick       (tick),
        .running    (running),
        .update     (update)
    );

    tick_divider u_divider
    (
        .clock   (clock),
        .rst_n   (rst_n),
        .running (running),
        .tick    (tick)
    );

    player_mover u_player
    (
        .clock    (clock),
        .rst_n    (rst_n),
        .update   (update),
        .up       (up),
        .down     (down),
        .left     (left),
        .right    (right),
        .player_x (player_x),
        .player_y (player_y)
    );

    car_mover u_cars
    (
        .clock  (clock),
        .rst_n  (rst_n),
        .update (update),
        .car_x  (car_x)
    );

    // New positions show one cycle after this pulse
    assign frame_update = update;

endmodule

//--- hw/tick_divider.sv
// ==========================================================
// Rate divider for the game tick, one pulse per tick period
// Count is cleared while the game is not running
// ==========================================================
`timescale 1ns/1ps

module tick_divider
(
    input  logic clock,
    input  logic rst_n,
    input  logic running,
    output logic tick
);

    import game_timing_pkg::*;

    tick_count_t count;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (!running)
        begin
            // Hold at zero so the first tick is a full period away
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == TICK_LAST)
        begin
            // Wrap and flag the tick for one cycle
            count <= '0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 4'd1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the road crosser testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_road_crosser \
    -f sources.f \
    -o tb_road_crosser

sim_out=$(./obj_dir/tb_road_crosser)
echo "$sim_out"
if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- sources.f
hw/game_geometry_pkg.sv
hw/game_timing_pkg.sv
hw/game_control.sv
hw/tick_divider.sv
hw/player_mover.sv
hw/car_mover.sv
hw/road_crosser_core.sv
test/road_crosser_props.sv
test/tb_road_crosser.sv

//--- test/road_crosser_props.sv
// ==========================================================
// Strobe and range assertions for the road crossing core
// Attached to every core instance by the bind below
// ==========================================================
`timescale 1ns/1ps

module road_crosser_props
(
    input logic                        clock,
    input logic                        rst_n,
    input logic                        running,
    input logic                        update,
    input game_geometry_pkg::coord_x_t player_x,
    input game_geometry_pkg::coord_y_t player_y
);

    import game_geometry_pkg::*;

    // Update strobe lasts a single cycle
    update_single: assert property (@(posedge clock) disable iff (!rst_n) update |=> !update)
        else $error("update stayed high for two cycles");

    // Player never leaves the grid
    x_in_grid: assert property (@(posedge clock) disable iff (!rst_n) player_x <= MAX_X)
        else $error("player_x beyond the last column");
    y_in_grid: assert property (@(posedge clock) disable iff (!rst_n) player_y <= MAX_Y)
        else $error("player_y beyond the last row");

    // No update before the game runs
    update_needs_run: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(update) |-> $past(running))
        else $error("update rose while the game was not running");

endmodule

bind road_crosser_core road_crosser_props u_props
(
    .clock    (clock),
    .rst_n    (rst_n),
    .running  (running),
    .update   (update),
    .player_x (player_x),
    .player_y (player_y)
);

//--- test/tb_road_crosser.sv
// ==========================================================
// Testbench for the road crossing core, LFSR buttons and start
// Compares every output with a cycle model on each falling edge
// ==========================================================
`timescale 1ns/1ps

module tb_road_crosser;

    import game_geometry_pkg::*;
    import game_timing_pkg::*;

    localparam int IDLE_CYCLES    = 20;
    localparam int RANDOM_UPDATES = 30;
    localparam int UP_UPDATES     = 115;
    localparam int MASK_UPDATES   = 5;
    localparam int LEFT_UPDATES   = 90;
    localparam int RIGHT_UPDATES  = 165;
    localparam int ALL_UPDATES    = RANDOM_UPDATES + UP_UPDATES + MASK_UPDATES
                                    + LEFT_UPDATES + RIGHT_UPDATES;
    // Two starts, two idle stretches, two resets and some slack
    localparam int MAX_CYCLES = (ALL_UPDATES + 4) * TICK_PERIOD + 2 * IDLE_CYCLES + 100;

    logic clock = 1'b0;
    logic rst_n;
    logic start_game;
    logic up;
    logic down;
    logic left;
    logic right;
    coord_x_t player_x;
    coord_y_t player_y;
    coord_x_t car_x [N_CARS];
    logic frame_update;

    // Model state
    ctrl_state_t m_state;
    tick_count_t m_count;
    logic m_tick;
    coord_x_t m_px;
    coord_y_t m_py;
    coord_x_t m_car [N_CARS];

    logic [31:0] lfsr_state = 32'd91541;
    int cycle = 0;
    int err_x = 0;
    int err_y = 0;
    int err_bit = 0;
    int err_other = 0;
    int last_pulse = 0;
    bit pulse_seen = 1'b0;
    bit first_pending = 1'b0;
    int wraps = 0;
    coord_x_t prev_car = '0;
    coord_x_t x_before;

    road_crosser_core UUT
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .start_game   (start_game),
        .up           (up),
        .down         (down),
        .left         (left),
        .right        (right),
        .player_x     (player_x),
        .player_y     (player_y),
        .car_x        (car_x),
        .frame_update (frame_update)
    );

    always #20 clock = ~clock;

    // 32 bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    task automatic check_x(input string name, input coord_x_t got, input coord_x_t exp);
        if (got !== exp)
        begin
            err_x++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_y(input string name, input coord_y_t got, input coord_y_t exp);
        if (got !== exp)
        begin
            err_y++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            err_bit++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_gap(input int got, input int exp);
        if (got != exp)
        begin
            err_other++;
            $display("Update pulses came %0d cycles apart instead of %0d", got, exp);
        end
    endtask

    // Reference model of FSM, divider, player step and car wrap
    always @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_state <= S_WAIT;
            m_count <= '0;
            m_tick  <= 1'b0;
            m_px    <= PLAYER_START_X;
            m_py    <= PLAYER_START_Y;
            for (int i = 0; i < N_CARS; i++)
                m_car[i] <= coord_x_t'(i * CAR_SPACING);
        end
        else
        begin
            if (m_state == S_WAIT && start_game)
                m_state <= S_WAIT_FOR_TICK;
            else if (m_state == S_WAIT_FOR_TICK && m_tick)
                m_state <= S_UPDATE;
            else if (m_state == S_UPDATE)
                m_state <= S_WAIT_FOR_TICK;
            // Divider runs only once started
            if (m_state == S_WAIT)
                m_count <= '0;
            else
                m_count <= (m_count == tick_count_t'(TICK_PERIOD - 1)) ? 4'd0 : m_count + 4'd1;
            m_tick <= (m_state != S_WAIT) && (m_count == tick_count_t'(TICK_PERIOD - 1));
            if (m_state == S_UPDATE)
            begin
                // Top pressed button wins even when blocked
                if (!up)
                    m_py <= (m_py == 7'd0) ? m_py : m_py - 7'd1;
                else if (!down)
                    m_py <= (m_py == MAX_Y) ? m_py : m_py + 7'd1;
                else if (!left)
                    m_px <= (m_px == 8'd0) ? m_px : m_px - 8'd1;
                else if (!right)
                    m_px <= (m_px == MAX_X) ? m_px : m_px + 8'd1;
                for (int i = 0; i < N_CARS; i++)
                    m_car[i] <= (m_car[i] == MAX_X) ? 8'd0 : m_car[i] + 8'd1;
            end
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clock)
    begin
        check_x("player_x", player_x, m_px);
        check_y("player_y", player_y, m_py);
        check_bit("frame_update", frame_update, m_state == S_UPDATE);
        for (int i = 0; i < N_CARS; i++)
            check_x($sformatf("car_x[%0d]", i), car_x[i], m_car[i]);
        if (prev_car == MAX_X && car_x[N_CARS - 1] == 8'd0)
            wraps++;
        prev_car = car_x[N_CARS - 1];
        // Pulse spacing, measured from the edge that takes start
        if (!rst_n)
        begin
            pulse_seen    = 1'b0;
            first_pending = 1'b0;
        end
        else
        begin
            if (frame_update)
            begin
                if (first_pending)
                    check_gap(cycle - last_pulse, TICK_PERIOD + 2);
                else if (pulse_seen)
                    check_gap(cycle - last_pulse, TICK_PERIOD);
                last_pulse    = cycle;
                pulse_seen    = 1'b1;
                first_pending = 1'b0;
            end
            if (m_state == S_WAIT && start_game)
            begin
                last_pulse    = cycle;
                first_pending = 1'b1;
            end
        end
    end

    always @(posedge clock)
    begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES)
        begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        rst_n      <= 1'b0;
        start_game <= 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    endtask

    // Random buttons with start held low
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clock);
            {up, down, left, right} <= {random_bit(), random_bit(), random_bit(), random_bit()};
            start_game <= 1'b0;
        end
    endtask

    task automatic check_reset_values();
        @(negedge clock);
        check_x("player_x", player_x, PLAYER_START_X);
        check_y("player_y", player_y, PLAYER_START_Y);
        check_bit("frame_update", frame_update, 1'b0);
        for (int i = 0; i < N_CARS; i++)
            check_x($sformatf("car_x[%0d]", i), car_x[i], coord_x_t'(i * CAR_SPACING));
    endtask

    // Buttons as {up, down, left, right}, random start bit every cycle
    task automatic run_updates(input logic [3:0] held, input bit use_random, input int n);
        int seen;
        logic [3:0] btn;
        seen = 0;
        while (seen < n)
        begin
            @(posedge clock);
            btn = held;
            if (use_random)
                btn = {random_bit(), random_bit(), random_bit(), random_bit()};
            {up, down, left, right} <= btn;
            start_game <= random_bit();
            @(negedge clock);
            if (frame_update)
                seen++;
        end
        // Let the last step land
        @(negedge clock);
    endtask

    initial
    begin
        rst_n      <= 1'b0;
        start_game <= 1'b0;
        {up, down, left, right} <= 4'b1111;
        apply_reset();
        idle_cycles(IDLE_CYCLES);
        check_reset_values();
        run_updates(4'b1111, 1'b1, RANDOM_UPDATES);
        // Reset in the middle of the run
        @(posedge clock);
        apply_reset();
        idle_cycles(IDLE_CYCLES);
        check_reset_values();
        run_updates(4'b0111, 1'b0, UP_UPDATES);
        check_y("player_y", player_y, 7'd0);
        x_before = player_x;
        // Up blocked at row 0 masks left
        run_updates(4'b0101, 1'b0, MASK_UPDATES);
        check_x("player_x", player_x, x_before);
        run_updates(4'b1101, 1'b0, LEFT_UPDATES);
        check_x("player_x", player_x, 8'd0);
        run_updates(4'b1110, 1'b0, RIGHT_UPDATES);
        check_x("player_x", player_x, MAX_X);
        if (wraps == 0)
        begin
            err_other++;
            $display("The last car never wrapped from the right edge to column 0");
        end
        $display("Error counts: x %0d, y %0d, bit %0d, other %0d",
                 err_x, err_y, err_bit, err_other);
        if (err_x + err_y + err_bit + err_other == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
